//--- Bender.yml
package:
  name: vga_text

sources:
  - logic/vga_text_pkg.sv
  - logic/vga_timing.sv
  - logic/text_dual_ram.sv
  - logic/text_fill_ctrl.sv
  - logic/vga_text.sv
  - logic/vga_text_top.sv
  - target: test
    files:
      - tests/vga_text_tb.sv

//--- logic/text_dual_ram.sv
`timescale 1ns/1ps

module text_dual_ram #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  payload_t                 wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output payload_t                 rdata
);

	// Storage, no reset
	payload_t mem [DEPTH];

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	////////////////////
	// Read port
	////////////////////

	// Registered read, old data on a same-address write
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

	// Out-of-range write would alias another entry
	assert property (@(posedge clk) we |-> (int'(waddr) < DEPTH))
		else $error("RAM write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

//--- logic/text_fill_ctrl.sv
`timescale 1ns/1ps

module text_fill_ctrl
	import vga_text_pkg::*;
#(
	parameter int CELLS = 4800
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   we,
	input  logic [CELL_ADDR_W-1:0] addr,
	input  text_cell_t             data,
	input  logic                   clear,
	input  text_cell_t             fill,
	output logic                   cell_we,
	output logic [CELL_ADDR_W-1:0] cell_addr,
	output text_cell_t             cell_data,
	output logic                   busy
);

	typedef enum logic {
		IDLE,
		SWEEP
	} state_t;

	state_t                 state;
	logic [CELL_ADDR_W-1:0] sweep_addr;   // Next cell to clear
	text_cell_t             fill_q;       // Latched fill value
	logic                   sweep_last;

	assign sweep_last = (sweep_addr == CELL_ADDR_W'(CELLS - 1));

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			sweep_addr <= '0;
		end else begin
			case (state)
				IDLE: begin
					sweep_addr <= '0;
					if (clear)
						state <= SWEEP; // busy from next cycle
				end
				SWEEP: begin
					sweep_addr <= sweep_addr + 1'b1;
					if (sweep_last)
						state <= IDLE; // Clear during sweep is ignored
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Fill value captured with the command
	always_ff @(posedge clk) begin
		if (state == IDLE && clear)
			fill_q <= fill;
	end

	assign busy = (state == SWEEP);

	// Host write drops out while sweeping
	assign cell_we   = busy ? 1'b1 : we;
	assign cell_addr = busy ? sweep_addr : addr;
	assign cell_data = busy ? fill_q : data;

	// Sweep covers every cell before releasing
	assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> ($past(sweep_addr) == CELL_ADDR_W'(CELLS - 1)))
		else $error("sweep ended early");

endmodule

//--- logic/vga_text.sv
`timescale 1ns/1ps

module vga_text
	import vga_text_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [31:0]             conf,
	input  logic [9:0]              column,
	input  logic [8:0]              row,
	input  logic                    active,
	input  logic                    hsync_in,
	input  logic                    vsync_in,
	input  logic                    cell_we,
	input  logic [CELL_ADDR_W-1:0]  cell_addr,
	input  text_cell_t              cell_data,
	input  logic                    font_we,
	input  logic [GLYPH_ADDR_W-1:0] font_addr,
	input  glyph_row_t              font_data,
	output color_t                  color_out,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    de
);

	localparam int COLS = H_ACTIVE / 8; // Text columns per line

	logic [1:0]              mode;
	logic                    mode_ok;
	logic [5:0]              char_row;
	logic [3:0]              glyph_line;
	logic [CELL_ADDR_W-1:0]  cell_raddr;
	logic [GLYPH_ADDR_W-1:0] glyph_raddr;
	text_cell_t              cell_q;    // Valid at +1
	glyph_row_t              glyph_q;   // Valid at +2

	// Stage 1 and 2 side band
	logic [3:0] line_s1;
	logic [2:0] col_s1, col_s2;
	logic       active_s1, active_s2;
	logic       ok_s1, ok_s2;
	logic       hsync_s1, hsync_s2;
	logic       vsync_s1, vsync_s2;
	color_t     fg_s2, bg_s2;

	////////////////////
	// Stage 0 address
	////////////////////

	assign mode    = conf[1:0];
	assign mode_ok = (mode == MODE_8X8) || (mode == MODE_8X16);

	// 16 lines per text row in 8x16, else 8
	assign char_row   = (mode == MODE_8X16) ? {1'b0, row[8:4]} : row[8:3];
	assign glyph_line = (mode == MODE_8X16) ? row[3:0] : {1'b0, row[2:0]};

	assign cell_raddr = CELL_ADDR_W'(char_row * COLS + column[9:3]);

	text_dual_ram #(
		.payload_t (text_cell_t),
		.DEPTH     (2 ** CELL_ADDR_W)
	) text_ram_i (
		.clk   (clk),
		.we    (cell_we),
		.waddr (cell_addr),
		.wdata (cell_data),
		.raddr (cell_raddr),
		.rdata (cell_q)
	);

	////////////////////
	// Stage 1 glyph
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			active_s1 <= 1'b0;
			ok_s1     <= 1'b0;
			hsync_s1  <= 1'b1; // Idle high
			vsync_s1  <= 1'b1;
		end else begin
			active_s1 <= active;
			ok_s1     <= mode_ok;
			hsync_s1  <= hsync_in;
			vsync_s1  <= vsync_in;
		end
	end

	always_ff @(posedge clk) begin
		line_s1 <= glyph_line;
		col_s1  <= column[2:0]; // Pixel within the character
	end

	// Code times 16 plus line
	assign glyph_raddr = {cell_q.code, line_s1};

	text_dual_ram #(
		.payload_t (glyph_row_t),
		.DEPTH     (2 ** GLYPH_ADDR_W)
	) glyph_ram_i (
		.clk   (clk),
		.we    (font_we),
		.waddr (font_addr),
		.wdata (font_data),
		.raddr (glyph_raddr),
		.rdata (glyph_q)
	);

	////////////////////
	// Stage 2 colour
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			active_s2 <= 1'b0;
			ok_s2     <= 1'b0;
			hsync_s2  <= 1'b1;
			vsync_s2  <= 1'b1;
		end else begin
			active_s2 <= active_s1;
			ok_s2     <= ok_s1;
			hsync_s2  <= hsync_s1;
			vsync_s2  <= vsync_s1;
		end
	end

	always_ff @(posedge clk) begin
		col_s2 <= col_s1;
		fg_s2  <= cell_q.fg; // Colours follow the glyph read
		bg_s2  <= cell_q.bg;
	end

	assign de    = active_s2;
	assign hsync = hsync_s2;
	assign vsync = vsync_s2;

	// Black in blanking and for unknown modes
	always_comb begin
		if (!active_s2 || !ok_s2)
			color_out = '0;
		else if (glyph_q[col_s2])
			color_out = fg_s2;
		else
			color_out = bg_s2;
	end

endmodule

//--- logic/vga_text_pkg.sv
package vga_text_pkg;

	////////////////////
	// Colours and cells
	////////////////////

	// 4 bits each of R, G, B
	typedef logic [11:0] color_t;

	// One character cell as the host writes it
	typedef struct packed {
		color_t     fg;   // Foreground
		color_t     bg;   // Background
		logic [7:0] code; // Character code
	} text_cell_t;

	// One glyph row, bit 0 is the leftmost pixel
	typedef logic [7:0] glyph_row_t;

	////////////////////
	// Modes and widths
	////////////////////

	localparam logic [1:0] MODE_8X8  = 2'b00;
	localparam logic [1:0] MODE_8X16 = 2'b10;

	// Text RAM address
	localparam int CELL_ADDR_W = 13;

	// Code times 16 plus glyph row
	localparam int GLYPH_ADDR_W = 12;

endpackage

//--- logic/vga_text_top.sv
`timescale 1ns/1ps

module vga_text_top
	import vga_text_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [31:0]             conf,
	input  logic                    we,
	input  logic [CELL_ADDR_W-1:0]  addr,
	input  text_cell_t              data,
	input  logic                    font_we,
	input  logic [GLYPH_ADDR_W-1:0] font_addr,
	input  glyph_row_t              font_data,
	input  logic                    clear,
	input  text_cell_t              fill,
	output color_t                  color_out,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    de,
	output logic                    busy
);

	// Cells on screen in 8x8 mode, the largest case
	localparam int CELLS = (H_ACTIVE / 8) * (V_ACTIVE / 8);

	logic [9:0]             column;
	logic [8:0]             row;
	logic                   active;
	logic                   raw_hsync, raw_vsync;
	logic                   cell_we;
	logic [CELL_ADDR_W-1:0] cell_addr;
	text_cell_t             cell_data;

	vga_timing #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
	) vga_timing_i (
		.clk (clk), .reset (reset), .column (column), .row (row),
		.active (active), .hsync (raw_hsync), .vsync (raw_vsync)
	);

	text_fill_ctrl #(.CELLS (CELLS)) text_fill_ctrl_i (
		.clk (clk), .reset (reset), .we (we), .addr (addr), .data (data),
		.clear (clear), .fill (fill), .cell_we (cell_we), .cell_addr (cell_addr),
		.cell_data (cell_data), .busy (busy)
	);

	// Two cycles behind the counters
	vga_text #(.H_ACTIVE (H_ACTIVE), .V_ACTIVE (V_ACTIVE)) vga_text_i (
		.clk (clk), .reset (reset), .conf (conf), .column (column), .row (row),
		.active (active), .hsync_in (raw_hsync), .vsync_in (raw_vsync),
		.cell_we (cell_we), .cell_addr (cell_addr), .cell_data (cell_data),
		.font_we (font_we), .font_addr (font_addr), .font_data (font_data),
		.color_out (color_out), .hsync (hsync), .vsync (vsync), .de (de)
	);

endmodule

//--- logic/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic       clk,
	input  logic       reset,
	output logic [9:0] column,
	output logic [8:0] row,
	output logic       active,
	output logic       hsync,
	output logic       vsync
);

	// Line and frame lengths
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Sync windows, active first then front porch
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	logic [9:0] h_count;
	logic [9:0] v_count;
	logic       h_last;   // Last pixel of the line
	logic       v_last;   // Last line of the frame

	assign h_last = (h_count == 10'(H_TOTAL - 1));
	assign v_last = (v_count == 10'(V_TOTAL - 1));

	////////////////////
	// Raster counters
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
		end else begin
			if (h_last) begin
				h_count <= '0;
				if (v_last)
					v_count <= '0; // New frame
				else
					v_count <= v_count + 10'd1;
			end else begin
				h_count <= h_count + 10'd1; // One pixel per clock
			end
		end
	end

	////////////////////
	// Decode
	////////////////////

	assign column = h_count;
	assign row    = v_count[8:0]; // Only meaningful inside the visible window

	assign active = (int'(h_count) < H_ACTIVE) && (int'(v_count) < V_ACTIVE);

	// Both syncs active low
	assign hsync = !((int'(h_count) >= H_SYNC_START) && (int'(h_count) < H_SYNC_END));
	assign vsync = !((int'(v_count) >= V_SYNC_START) && (int'(v_count) < V_SYNC_END));

	// Horizontal sync pulse must sit in blanking
	assert property (@(posedge clk) disable iff (reset) active |-> hsync)
		else $error("hsync low inside the visible window");

endmodule

//--- project.f
logic/vga_text_pkg.sv
logic/vga_timing.sv
logic/text_dual_ram.sv
logic/text_fill_ctrl.sv
logic/vga_text.sv
logic/vga_text_top.sv
tests/vga_text_tb.sv

//--- tests/vga_text_tb.sv
`timescale 1ns/1ps

module vga_text_tb
	import vga_text_pkg::*;
();

	////////////////////
	// Screen geometry
	////////////////////

	localparam int H_ACTIVE = 64;
	localparam int H_FRONT  = 2;
	localparam int H_SYNC   = 4;
	localparam int H_BACK   = 2;
	localparam int V_ACTIVE = 32;
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 1;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // Clocks per line
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // Lines per frame
	localparam int FRAME    = H_TOTAL * V_TOTAL;   // Clocks per frame
	localparam int BUSY_LIMIT = 256;  // A 32 cell sweep fits easily

	logic                    clk = 1'b0;
	logic                    reset;
	logic [31:0]             conf;
	logic                    we;
	logic [CELL_ADDR_W-1:0]  addr;
	text_cell_t              data;
	logic                    font_we;
	logic [GLYPH_ADDR_W-1:0] font_addr;
	glyph_row_t              font_data;
	logic                    clear;
	text_cell_t              fill;
	color_t                  color_out;
	logic                    hsync, vsync, de, busy;

	string test_name = "none";  // Current T section
	int    checks    = 0;

	vga_text_top #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
	) vga_text_top_i (
		.clk (clk), .reset (reset), .conf (conf), .we (we), .addr (addr), .data (data),
		.font_we (font_we), .font_addr (font_addr), .font_data (font_data),
		.clear (clear), .fill (fill), .color_out (color_out), .hsync (hsync),
		.vsync (vsync), .de (de), .busy (busy)
	);

	always #5 clk = ~clk; // 10 ns period

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
			abort_run("value mismatch");
		end
	endtask

	task automatic fields_ok(input int got, input int want);
		if (got != want)
			abort_run("malformed line in the trace file");
	endtask

	// One cycle strobes, all on the falling edge
	task automatic write_cell(input logic [CELL_ADDR_W-1:0] a, input text_cell_t c);
		@(negedge clk);
		we   = 1'b1;
		addr = a;
		data = c;
		@(negedge clk);
		we = 1'b0;
	endtask

	task automatic write_glyph(input logic [GLYPH_ADDR_W-1:0] a, input glyph_row_t r);
		@(negedge clk);
		font_we   = 1'b1;
		font_addr = a;
		font_data = r;
		@(negedge clk);
		font_we = 1'b0;
	endtask

	task automatic start_clear(input text_cell_t c);
		@(negedge clk);
		clear = 1'b1;
		fill  = c;
		@(negedge clk);
		clear = 1'b0;
		check_value("busy after clear", 32'd1, {31'd0, busy}); // High one cycle later
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy) begin
			@(negedge clk);
			n++;
			if (n > BUSY_LIMIT)
				abort_run("timeout waiting for the clear sweep to finish");
		end
	endtask

	task automatic wait_vsync_fall();
		int   n;
		logic prev;
		n    = 0;
		prev = vsync;
		@(negedge clk);
		while (!(prev && !vsync)) begin
			prev = vsync;
			@(negedge clk);
			n++;
			if (n > 2 * FRAME)
				abort_run("timeout waiting for vsync to fall");
		end
	endtask

	// Walks one whole frame, checks framing and grabs one pixel
	task automatic capture_pixel(input int x, input int y, input color_t expected);
		int     n, lines, line_de, pix, target, hs_falls, since_de;
		logic   prev_de, prev_vs, prev_hs, done;
		color_t seen;
		wait_idle();
		wait_vsync_fall();
		target   = y * H_ACTIVE + x;
		n        = 0;
		lines    = 0;
		line_de  = 0;
		pix      = 0;
		hs_falls = 0;
		since_de = H_TOTAL; // No active line seen yet
		prev_de  = 1'b0;
		done     = 1'b0;
		seen     = 'x;
		while (!done) begin
			prev_vs = vsync;
			prev_hs = hsync;
			@(negedge clk);
			n++;
			if (n > 2 * FRAME)
				abort_run("timeout while capturing a frame");
			if (de) begin
				check_value("hsync inside active", 32'd1, {31'd0, hsync});
				if (pix == target)
					seen = color_out;
				pix++;
				line_de++;
			end else begin
				check_value("color_out in blanking", 32'd0, 32'(color_out));
				if (prev_de) begin // End of an active line
					check_value("pixels per line", H_ACTIVE, line_de);
					lines++;
					line_de  = 0;
					since_de = 0;
				end else begin
					since_de++;
				end
			end
			if (prev_hs && !hsync) begin
				hs_falls++;
				// Sync pulse follows the front porch
				if (since_de < H_TOTAL)
					check_value("hsync after active line", H_FRONT, since_de);
			end
			prev_de = de;
			done    = prev_vs && !vsync; // Next frame starts
		end
		check_value("lines per frame", V_ACTIVE, lines);
		check_value("hsync pulses per frame", V_TOTAL, hs_falls);
		check_value($sformatf("pixel %0d,%0d", x, y), 32'(expected), 32'(seen));
	endtask

	////////////////////
	// Trace replay
	////////////////////

	initial begin
		int              fd;
		int              got;
		logic [7:0]      op;
		logic [31:0]     a, b, c, d;
		logic [8*200-1:0] skip_buf;
		reset     = 1'b1;
		conf      = '0;
		we        = 1'b0;
		addr      = '0;
		data      = '0;
		font_we   = 1'b0;
		font_addr = '0;
		font_data = '0;
		clear     = 1'b0;
		fill      = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		fd = $fopen("tests/vga_text_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open tests/vga_text_trace.txt");
		got = $fscanf(fd, " %c", op);
		while (got == 1) begin
			case (op)
				"#": got = $fgets(skip_buf, fd); // Comment line
				"T": begin
					got = $fscanf(fd, " %s", test_name);
					fields_ok(got, 1);
					$display("Test %s", test_name);
				end
				"W": begin
					got = $fscanf(fd, " %h %h %h %h", a, b, c, d);
					fields_ok(got, 4);
					write_cell(a[CELL_ADDR_W-1:0], {b[11:0], c[11:0], d[7:0]});
				end
				"F": begin
					got = $fscanf(fd, " %h %h", a, b);
					fields_ok(got, 2);
					write_glyph(a[GLYPH_ADDR_W-1:0], b[7:0]);
				end
				"C": begin
					got = $fscanf(fd, " %h %h %h", a, b, c);
					fields_ok(got, 3);
					start_clear({a[11:0], b[11:0], c[7:0]});
				end
				"M": begin
					got = $fscanf(fd, " %h", a);
					fields_ok(got, 1);
					@(negedge clk);
					conf = a;
				end
				"P": begin
					got = $fscanf(fd, " %d %d %h", a, b, c);
					fields_ok(got, 3);
					capture_pixel(a, b, c[11:0]);
				end
				default: abort_run("unknown opcode in the trace file");
			endcase
			got = $fscanf(fd, " %c", op);
		end
		$fclose(fd);
		if (checks == 0) begin
			abort_run("trace file held no checks");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- tests/vga_text_trace.txt
# T name | W cell fg bg code | F glyph_addr row_bits | C fg bg code
# M mode | P x y colour, with x and y decimal and all else hex
T glyphs_8x8
F 010 01
F 011 80
F 01b 04
F 020 f0
F 023 55
F 029 08
F 030 00
F 033 ff
F 036 10
W 000 f00 00f 01
W 001 0f0 111 02
W 008 fff 222 02
M 0
P 0 0 f00
P 1 0 00f
P 7 1 f00
P 6 1 00f
P 12 0 0f0
P 11 3 111
P 2 11 fff
T glyphs_8x16
M 2
P 0 0 f00
P 7 1 f00
P 12 0 0f0
P 11 3 111
P 2 11 f00
P 3 25 fff
T bad_mode
M 1
P 0 0 000
P 2 11 000
P 60 30 000
T clear
M 0
C abc 123 03
W 001 fff fff 01
P 0 0 123
P 12 0 123
P 2 11 abc
P 60 30 abc
P 61 30 123
T overwrite
W 01f 0f0 f0f 03
P 60 30 0f0
P 61 30 f0f
W 01f 00f ff0 03
P 60 30 00f
